// ==== all.f ====
+incdir+src
src/gpioPkg.sv
src/segCfgIf.sv
src/gpioRegFile.sv
src/scanTimer.sv
src/sevenSegScanner.sv
src/gpioPeripheral.sv
dv/gpioChecker.sv
dv/gpioPeripheralTb.sv

// ==== dv/gpioPeripheralTb.sv ====
`timescale 1ns/1ns
`include "gpio_settings.svh"

module gpioPeripheralTb;
    import gpioPkg::*;

    localparam regAddr_t AddrIn   = regAddr_t'(`GPIO_REG_IN);
    localparam regAddr_t AddrOut  = regAddr_t'(`GPIO_REG_OUT);
    localparam regAddr_t AddrDdr  = regAddr_t'(`GPIO_REG_DDR);
    localparam regAddr_t AddrSeg  = regAddr_t'(`GPIO_REG_7SEG);
    localparam int       EnTimeout = 40; // a digit change is due every 16 cycles.

    logic        clk;
    logic        rstN;
    logic        slaveSel;
    regAddr_t    regAddr;
    byteEn_t     byteEn;
    logic        avRead;
    logic        avWrite;
    busWord_t    writeData;
    busWord_t    readData;
    gpioPins_t   gpioIn;
    gpioPins_t   gpioOut;
    gpioPins_t   gpioOe;
    digitEn_t    segEn;
    segPattern_t segLed;
    busWord_t    expRdData;
    logic        ledCheckEn;
    int          checkCount;
    int          errCount;
    logic [31:0] lfsrState;
    gpioPins_t   outM;
    gpioPins_t   ddrM;
    gpioPins_t   pinM;
    segPattern_t segOneM;
    segPattern_t segTwoM;
    segPattern_t segThreeM;
    logic        lutM;
    segPattern_t expSegOne;
    segPattern_t expSegTwo;
    segPattern_t expSegThree;

    gpioPeripheral gpioPeripheral_inst (
        .i_Clk(clk), .i_rstN(rstN), .i_SlaveSel(slaveSel), .i_RegAddr(regAddr),
        .i_AV_ByteEn(byteEn), .i_AV_Read(avRead), .i_AV_Write(avWrite),
        .i_AV_WriteData(writeData), .o_AV_ReadData(readData), .i_GpioIn(gpioIn),
        .o_GpioOut(gpioOut), .o_GpioOe(gpioOe), .o_7Seg_En(segEn), .o_7Seg_Led(segLed)
    );

    gpioChecker gpioChecker_inst (
        .i_Clk(clk), .i_rstN(rstN), .i_SlaveSel(slaveSel), .i_AV_Read(avRead),
        .i_AV_ReadData(readData), .i_GpioOut(gpioOut), .i_GpioOe(gpioOe),
        .i_7Seg_En(segEn), .i_7Seg_Led(segLed), .i_ExpRdData(expRdData),
        .i_ExpGpioOut(outM), .i_ExpGpioOe(ddrM), .i_ExpSegOne(expSegOne),
        .i_ExpSegTwo(expSegTwo), .i_ExpSegThree(expSegThree), .i_LedCheckEn(ledCheckEn),
        .o_CheckCount(checkCount), .o_ErrCount(errCount)
    );

    initial begin
        clk = 1'b1;
        forever #20 clk = ~clk;
    end

    // fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            val = {val[30:0], lfsrState[0]};
        end
        return val;
    endfunction

    function automatic segPattern_t expectedSegment(input segPattern_t field, input logic lut);
        return lut ? hexGlyph(field) : field;
    endfunction

    assign expSegOne   = expectedSegment(segOneM, lutM);
    assign expSegTwo   = expectedSegment(segTwoM, lutM);
    assign expSegThree = expectedSegment(segThreeM, lutM);

    function automatic busWord_t expectedRead(input regAddr_t addr);
        busWord_t word;
        word = '0;
        if (addr == AddrIn) begin
            word = busWord_t'(pinM);
        end else if (addr == AddrOut) begin
            word = busWord_t'(outM);
        end else if (addr == AddrDdr) begin
            word = busWord_t'(ddrM);
        end else begin
            word[6:0]   = segOneM;
            word[14:8]  = segTwoM;
            word[22:16] = segThreeM;
            word[24]    = lutM;
        end
        return word;
    endfunction

    task automatic modelWrite(input regAddr_t addr, input busWord_t data, input byteEn_t be);
        busWord_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        if (addr == AddrOut) begin
            outM = gpioPins_t'((busWord_t'(outM) & ~mask) | (data & mask));
        end else if (addr == AddrDdr) begin
            ddrM = gpioPins_t'((busWord_t'(ddrM) & ~mask) | (data & mask));
        end else if (addr == AddrSeg) begin
            if (be[0]) segOneM = data[6:0];
            if (be[1]) segTwoM = data[14:8];
            if (be[2]) segThreeM = data[22:16];
            if (be[3]) lutM = data[24];
        end
    endtask

    task automatic busWrite(input regAddr_t addr, input busWord_t data, input byteEn_t be);
        @(posedge clk);
        slaveSel  <= 1'b1;
        avWrite   <= 1'b1;
        regAddr   <= addr;
        byteEn    <= be;
        writeData <= data;
        @(posedge clk);
        slaveSel <= 1'b0;
        avWrite  <= 1'b0;
        modelWrite(addr, data, be); // the DUT takes the write on this same edge.
    endtask

    task automatic busRead(input regAddr_t addr);
        @(posedge clk);
        slaveSel  <= 1'b1;
        avRead    <= 1'b1;
        regAddr   <= addr;
        expRdData <= expectedRead(addr);
        @(posedge clk);
        slaveSel <= 1'b0;
        avRead   <= 1'b0;
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $finish;
    endtask

    task automatic waitDigitChange();
        digitEn_t prev;
        int       cycles;
        @(negedge clk);
        prev   = segEn;
        cycles = 0;
        while (segEn === prev && cycles < EnTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (segEn === prev) begin
            abortRun("timeout: the digit enable did not change for 40 cycles");
        end
    endtask

    task automatic scanDisplay(input logic lut);
        busWord_t data;
        data     = randBits(32);
        data[24] = lut;
        busWrite(AddrSeg, data, 4'hF);
        @(negedge clk); // a digit change on the write edge still shows the old fields.
        ledCheckEn <= 1'b1;
        repeat (6) waitDigitChange();
        ledCheckEn <= 1'b0;
    endtask

    task automatic finishTest(input int num, input string name, input int errMark);
        repeat (2) @(posedge clk);
        if (errCount == errMark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errCount - errMark);
        end
    endtask

    initial begin
        int        errMark;
        busWord_t  data;
        gpioPins_t pins;
        lfsrState  = 32'h61aa82b8;
        rstN       = 1'b0;
        slaveSel   = 1'b0;
        regAddr    = '0;
        byteEn     = '0;
        avRead     = 1'b0;
        avWrite    = 1'b0;
        writeData  = '0;
        gpioIn     = '0;
        expRdData  = '0;
        ledCheckEn = 1'b0;
        outM       = '0;
        ddrM       = '0;
        pinM       = '0;
        segOneM    = '0;
        segTwoM    = '0;
        segThreeM  = '0;
        lutM       = 1'b0;
        @(negedge clk);
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        errMark = errCount;
        for (int a = 0; a < 4; a++) begin
            busRead(regAddr_t'(a));
        end
        finishTest(1, "reset values", errMark);

        errMark = errCount;
        for (int i = 0; i < 12; i++) begin
            data = randBits(32);
            busWrite(AddrSeg, data, byteEn_t'(randBits(4)));
            busRead(AddrSeg);
        end
        finishTest(2, "display register byte writes", errMark);

        errMark = errCount;
        for (int i = 0; i < 8; i++) begin
            busWrite(AddrOut, randBits(32), byteEn_t'(randBits(4)));
            busWrite(AddrDdr, randBits(32), byteEn_t'(randBits(4)));
            busRead(AddrOut);
            busRead(AddrDdr);
        end
        busWrite(AddrIn, randBits(32), 4'hF);
        for (int a = 0; a < 4; a++) begin
            busRead(regAddr_t'(a));
        end
        finishTest(3, "output and direction registers", errMark);

        errMark = errCount;
        for (int i = 0; i < 8; i++) begin
            pins = gpioPins_t'(randBits(`GPIO_WIDTH));
            @(posedge clk);
            gpioIn <= pins;
            pinM = pins;
            repeat (3) @(posedge clk); // covers the two synchronizer flops.
            busRead(AddrIn);
        end
        finishTest(4, "input pin sampling", errMark);

        errMark = errCount;
        scanDisplay(1'b0);
        scanDisplay(1'b1);
        finishTest(5, "display scan raw and hex", errMark);

        errMark = errCount;
        @(posedge clk);
        avRead  <= 1'b1;
        regAddr <= regAddr_t'(randBits(2));
        repeat (3) @(posedge clk);
        slaveSel <= 1'b1;
        avRead   <= 1'b0;
        repeat (3) @(posedge clk);
        slaveSel <= 1'b0;
        finishTest(6, "idle bus read data", errMark);

        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

// ==== dv/gpioChecker.sv ====
`timescale 1ns/1ns

module gpioChecker (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    input  logic                 i_SlaveSel,
    input  logic                 i_AV_Read,
    input  gpioPkg::busWord_t    i_AV_ReadData,
    input  gpioPkg::gpioPins_t   i_GpioOut,
    input  gpioPkg::gpioPins_t   i_GpioOe,
    input  gpioPkg::digitEn_t    i_7Seg_En,
    input  gpioPkg::segPattern_t i_7Seg_Led,
    input  gpioPkg::busWord_t    i_ExpRdData,
    input  gpioPkg::gpioPins_t   i_ExpGpioOut,
    input  gpioPkg::gpioPins_t   i_ExpGpioOe,
    input  gpioPkg::segPattern_t i_ExpSegOne,
    input  gpioPkg::segPattern_t i_ExpSegTwo,
    input  gpioPkg::segPattern_t i_ExpSegThree,
    input  logic                 i_LedCheckEn,
    output int                   o_CheckCount,
    output int                   o_ErrCount
);
    import gpioPkg::*;

    logic        rdPending;
    busWord_t    rdExpected;
    digitEn_t    lastEn;
    segPattern_t ledExpected;

    task automatic compareValue(input string what, input busWord_t got, input busWord_t exp);
        o_CheckCount++;
        if (got !== exp) begin
            o_ErrCount++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        o_CheckCount = 0;
        o_ErrCount   = 0;
        rdPending    = 1'b0;
        rdExpected   = '0;
        lastEn       = 3'b001;
    end

    // the falling edge sits half a cycle away from every DUT register update.
    always @(negedge i_Clk) begin
        if (!i_rstN) begin
            compareValue("read data in reset", i_AV_ReadData, '0);
            compareValue("digit enable in reset", busWord_t'(i_7Seg_En), 32'd1);
            lastEn = 3'b001;
        end else begin
            compareValue("read data", i_AV_ReadData, rdPending ? rdExpected : '0);
            if (i_7Seg_En !== lastEn) begin
                compareValue("digit enable", busWord_t'(i_7Seg_En),
                             busWord_t'({lastEn[1:0], lastEn[2]})); // one-hot rotates left.
                if (i_LedCheckEn) begin
                    case (i_7Seg_En)
                        3'b001:  ledExpected = i_ExpSegOne;
                        3'b010:  ledExpected = i_ExpSegTwo;
                        default: ledExpected = i_ExpSegThree;
                    endcase
                    compareValue("segments", busWord_t'(i_7Seg_Led), busWord_t'(ledExpected));
                end
                lastEn = i_7Seg_En;
            end
        end
        compareValue("gpio out", busWord_t'(i_GpioOut), busWord_t'(i_ExpGpioOut));
        compareValue("gpio oe", busWord_t'(i_GpioOe), busWord_t'(i_ExpGpioOe));
        // a read seen now is sampled by the next rising edge and answered after it.
        rdPending  = i_rstN && i_SlaveSel && i_AV_Read;
        rdExpected = i_ExpRdData;
    end
endmodule

// ==== src/gpioPeripheral.sv ====
`timescale 1ns/1ns
`include "gpio_settings.svh"

module gpioPeripheral (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    // avalon slave port.
    input  logic                 i_SlaveSel,
    input  gpioPkg::regAddr_t    i_RegAddr,
    input  gpioPkg::byteEn_t     i_AV_ByteEn,
    input  logic                 i_AV_Read,
    input  logic                 i_AV_Write,
    input  gpioPkg::busWord_t    i_AV_WriteData,
    output gpioPkg::busWord_t    o_AV_ReadData,
    // gpio pins with the output enable brought out for the pad ring.
    input  gpioPkg::gpioPins_t   i_GpioIn,
    output gpioPkg::gpioPins_t   o_GpioOut,
    output gpioPkg::gpioPins_t   o_GpioOe,
    // seven segment display.
    output gpioPkg::digitEn_t    o_7Seg_En,
    output gpioPkg::segPattern_t o_7Seg_Led
);
    segCfgIf segCfg ();

    gpioRegFile gpioRegFile_inst (
        .i_Clk          (i_Clk),
        .i_rstN         (i_rstN),
        .i_SlaveSel     (i_SlaveSel),
        .i_RegAddr      (i_RegAddr),
        .i_AV_ByteEn    (i_AV_ByteEn),
        .i_AV_Read      (i_AV_Read),
        .i_AV_Write     (i_AV_Write),
        .i_AV_WriteData (i_AV_WriteData),
        .o_AV_ReadData  (o_AV_ReadData),
        .i_GpioIn       (i_GpioIn),
        .o_GpioOut      (o_GpioOut),
        .o_GpioOe       (o_GpioOe),
        .segCfg         (segCfg.source)
    );

    scanTimer #(
        .DivLog2 (`GPIO_SCAN_DIV_LOG2)
    ) scanTimer_inst (
        .i_Clk  (i_Clk),
        .i_rstN (i_rstN),
        .segCfg (segCfg.timer)
    );

    sevenSegScanner sevenSegScanner_inst (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .segCfg     (segCfg.sink),
        .o_7Seg_En  (o_7Seg_En),
        .o_7Seg_Led (o_7Seg_Led)
    );
endmodule

// ==== src/sevenSegScanner.sv ====
`timescale 1ns/1ns

module sevenSegScanner (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    segCfgIf.sink                segCfg,
    output gpioPkg::digitEn_t    o_7Seg_En,
    output gpioPkg::segPattern_t o_7Seg_Led
);
    import gpioPkg::*;

    digitSel_e   digitSel;
    digitSel_e   nextSel;
    digitEn_t    nextEn;
    segPattern_t nextField;
    segPattern_t nextLed;

    always_comb begin
        case (digitSel)
            DIGIT_ONE: nextSel = DIGIT_TWO;
            DIGIT_TWO: nextSel = DIGIT_THREE;
            default:   nextSel = DIGIT_ONE;
        endcase
    end

    // the enable and field are looked up for the digit about to be shown.
    always_comb begin
        case (nextSel)
            DIGIT_ONE: begin
                nextEn    = 3'b001;
                nextField = segCfg.segOne;
            end
            DIGIT_TWO: begin
                nextEn    = 3'b010;
                nextField = segCfg.segTwo;
            end
            default: begin
                nextEn    = 3'b100;
                nextField = segCfg.segThree;
            end
        endcase
    end

    assign nextLed = segCfg.hexLutEn ? hexGlyph(nextField) : nextField;

    // enable and segments are loaded on the same edge so they never disagree.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            digitSel   <= DIGIT_ONE;
            o_7Seg_En  <= 3'b001;
            o_7Seg_Led <= '0;
        end else if (segCfg.tick) begin
            digitSel   <= nextSel;
            o_7Seg_En  <= nextEn;
            o_7Seg_Led <= nextLed;
        end
    end
endmodule

// ==== src/scanTimer.sv ====
`timescale 1ns/1ns
`include "gpio_settings.svh"

module scanTimer #(
    parameter int DivLog2 = `GPIO_SCAN_DIV_LOG2
) (
    input  logic    i_Clk,
    input  logic    i_rstN,
    segCfgIf.timer  segCfg
);
    logic [DivLog2-1:0] divCount;

    // the tick is a clock enable so the display logic stays on i_Clk.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            divCount    <= '0;
            segCfg.tick <= 1'b0;
        end else begin
            divCount    <= divCount + 1'b1;
            segCfg.tick <= &divCount; // high for one cycle after the count wraps.
        end
    end
endmodule

// ==== src/gpioRegFile.sv ====
`timescale 1ns/1ns
`include "gpio_settings.svh"

module gpioRegFile (
    input  logic               i_Clk,
    input  logic               i_rstN,
    // avalon slave port.
    input  logic               i_SlaveSel,
    input  gpioPkg::regAddr_t  i_RegAddr,
    input  gpioPkg::byteEn_t   i_AV_ByteEn,
    input  logic               i_AV_Read,
    input  logic               i_AV_Write,
    input  gpioPkg::busWord_t  i_AV_WriteData,
    output gpioPkg::busWord_t  o_AV_ReadData,
    // pins.
    input  gpioPkg::gpioPins_t i_GpioIn,
    output gpioPkg::gpioPins_t o_GpioOut,
    output gpioPkg::gpioPins_t o_GpioOe,
    segCfgIf.source            segCfg
);
    import gpioPkg::*;

    logic        wrEn;
    logic        rdEn;
    gpioPins_t   pinSyncA;
    gpioPins_t   pinSyncB;
    segPattern_t segOne;
    segPattern_t segTwo;
    segPattern_t segThree;
    logic        hexLutEn;
    busWord_t    rdMux;

    // replaces the enabled bytes of oldWord with those of newWord.
    function automatic busWord_t mergeBytes(
        input busWord_t oldWord,
        input busWord_t newWord,
        input byteEn_t  byteEn
    );
        busWord_t merged;
        merged = oldWord;
        for (int i = 0; i < $bits(byteEn_t); i++) begin
            if (byteEn[i]) begin
                merged[i*8 +: 8] = newWord[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign wrEn = i_SlaveSel && i_AV_Write;
    assign rdEn = i_SlaveSel && i_AV_Read;

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_GpioOut <= '0;
            o_GpioOe  <= '0; // every pin starts as an input.
            segOne    <= '0;
            segTwo    <= '0;
            segThree  <= '0;
            hexLutEn  <= 1'b0;
        end else if (wrEn) begin
            case (i_RegAddr)
                `GPIO_REG_OUT: begin
                    o_GpioOut <= gpioPins_t'(mergeBytes(busWord_t'(o_GpioOut),
                                                        i_AV_WriteData, i_AV_ByteEn));
                end
                `GPIO_REG_DDR: begin
                    o_GpioOe <= gpioPins_t'(mergeBytes(busWord_t'(o_GpioOe),
                                                       i_AV_WriteData, i_AV_ByteEn));
                end
                `GPIO_REG_7SEG: begin
                    if (i_AV_ByteEn[0]) segOne   <= i_AV_WriteData[6:0];
                    if (i_AV_ByteEn[1]) segTwo   <= i_AV_WriteData[14:8];
                    if (i_AV_ByteEn[2]) segThree <= i_AV_WriteData[22:16];
                    if (i_AV_ByteEn[3]) hexLutEn <= i_AV_WriteData[24];
                end
                default: begin
                    // the input register is read only.
                end
            endcase
        end
    end

    // two flops ahead of the bus because the pins are asynchronous to i_Clk.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            pinSyncA <= '0;
            pinSyncB <= '0;
        end else begin
            pinSyncA <= i_GpioIn;
            pinSyncB <= pinSyncA;
        end
    end

    always_comb begin
        case (i_RegAddr)
            `GPIO_REG_IN:   rdMux = busWord_t'(pinSyncB);
            `GPIO_REG_OUT:  rdMux = busWord_t'(o_GpioOut);
            `GPIO_REG_DDR:  rdMux = busWord_t'(o_GpioOe);
            `GPIO_REG_7SEG: rdMux = {7'b0, hexLutEn, 1'b0, segThree, 1'b0, segTwo,
                                     1'b0, segOne};
            default:        rdMux = '0;
        endcase
    end

    // read data is valid for exactly one cycle and zero otherwise.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_AV_ReadData <= '0;
        end else begin
            o_AV_ReadData <= rdEn ? rdMux : '0;
        end
    end

    assign segCfg.segOne   = segOne;
    assign segCfg.segTwo   = segTwo;
    assign segCfg.segThree = segThree;
    assign segCfg.hexLutEn = hexLutEn;
endmodule

// ==== src/segCfgIf.sv ====
`timescale 1ns/1ns

// display configuration shared by the register block, the scan timer and the scanner.
interface segCfgIf;
    import gpioPkg::*;

    segPattern_t segOne;
    segPattern_t segTwo;
    segPattern_t segThree;
    logic        hexLutEn; // 1 selects the hex glyph lookup.
    logic        tick;     // one-cycle digit advance strobe.

    modport source (
        output segOne, segTwo, segThree, hexLutEn
    );

    modport timer (
        output tick
    );

    modport sink (
        input segOne, segTwo, segThree, hexLutEn, tick
    );
endinterface

// ==== src/gpioPkg.sv ====
`include "gpio_settings.svh"

package gpioPkg;

    typedef logic [31:0]                     busWord_t;
    typedef logic [3:0]                      byteEn_t;
    typedef logic [29-`GPIO_ADDR_SEL_BITS:0] regAddr_t;
    typedef logic [`GPIO_WIDTH-1:0]          gpioPins_t;
    typedef logic [6:0]                      segPattern_t; // gfedcba with 1 for a lit segment.
    typedef logic [2:0]                      digitEn_t;    // one-hot with bit 0 for digit one.

    typedef enum logic [1:0] {
        DIGIT_ONE,
        DIGIT_TWO,
        DIGIT_THREE
    } digitSel_e;

    // common-cathode glyphs for 0-F with lower-case b and d.
    function automatic segPattern_t hexGlyph(input segPattern_t field);
        segPattern_t glyph;
        case (field[3:0])
            4'h0: glyph = 7'b0111111;
            4'h1: glyph = 7'b0000110;
            4'h2: glyph = 7'b1011011;
            4'h3: glyph = 7'b1001111;
            4'h4: glyph = 7'b1100110;
            4'h5: glyph = 7'b1101101;
            4'h6: glyph = 7'b1111101;
            4'h7: glyph = 7'b0000111;
            4'h8: glyph = 7'b1111111;
            4'h9: glyph = 7'b1101111;
            4'hA: glyph = 7'b1110111;
            4'hB: glyph = 7'b1111100;
            4'hC: glyph = 7'b0111001;
            4'hD: glyph = 7'b1011110;
            4'hE: glyph = 7'b1111001;
            default: glyph = 7'b1110001;
        endcase
        return glyph;
    endfunction

endpackage

// ==== src/gpio_settings.svh ====
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// number of GPIO pins behind the peripheral.
`define GPIO_WIDTH 16

// the interconnect consumes the upper address bits and leaves a 2-bit word address.
`define GPIO_ADDR_SEL_BITS 28

// register word addresses.
`define GPIO_REG_IN   0
`define GPIO_REG_OUT  1
`define GPIO_REG_DDR  2
`define GPIO_REG_7SEG 3

// the scanner moves to the next digit once every 2**N clock cycles.
`define GPIO_SCAN_DIV_LOG2 4

`endif
